// File: design/wb_pkg.sv
// writeback stage shared types
package wb_pkg;

   // width of a register write
   typedef enum logic [1:0] {
      ds_byte  = 2'd0,
      ds_word  = 2'd1,
      ds_dword = 2'd2
   } datasize_t;

   // named view of the flags word with bit 0 at the bottom
   typedef struct packed {
      logic [19:0] rsvd_31_12;
      logic        of;
      logic        df;
      logic [1:0]  rsvd_9_8;
      logic        sf;
      logic        zf;
      logic        rsvd_5;
      logic        af;
      logic        rsvd_3;
      logic        pf;
      logic        rsvd_1;
      logic        cf;
   } flags_bits_t;

   typedef union packed {
      logic [31:0] raw;
      flags_bits_t bits;
   } flags_word_t;

   // OF DF SF ZF AF PF CF
   localparam logic [31:0] FLAGS_DEFINED_MASK = 32'h0000_0cd5;

   typedef struct packed {
      logic        valid;
      logic [31:0] next_eip;
      datasize_t   datasize;
      logic [2:0]  dr1;
      logic [2:0]  dr2;
      logic [2:0]  dr3;
      logic [31:0] result_a;
      logic [31:0] result_b;
      logic [31:0] result_c;
      flags_word_t flags;
      logic [31:0] flags_affected;
      logic [31:0] store_addr;
      logic        ld_gpr1;
      logic        ld_gpr2;
      logic        ld_gpr3;
      logic        ld_flags;
      logic        ld_eip;
      logic        store;
      logic        is_cmps_first;
      logic        is_cmps_second;
      logic        is_jne;
      logic        is_jnbe;
      logic        is_cmovc;
      logic        is_halt;
      logic        repne;
   } wb_uop_t;

   // wishbone master to slave
   typedef struct packed {
      logic        cyc;
      logic        stb;
      logic        we;
      logic [31:0] adr;
      logic [31:0] dat;
      logic [3:0]  sel;
   } wb_m2s_t;

   typedef struct packed {
      logic ack;
   } wb_s2m_t;

   // one register file write port
   typedef struct packed {
      logic        en;
      logic [2:0]  num;
      logic [31:0] data;
      datasize_t   size;
   } gpr_wr_t;

endpackage

// File: design/cmps_pointer_hold.sv
// cmps pointer hold
`timescale 1ns/1ps

module cmps_pointer_hold
   import wb_pkg::*;
(
   input  logic        CLK,
   input  logic        rst,
   input  logic        capture,
   input  logic        use_held,
   input  logic [31:0] result_a,
   output logic [31:0] data1
);

   logic [31:0] held_ptr;

   // first cmps uop computes the pointer, second one writes it back
   always_ff @(posedge CLK) begin
      if (rst) begin
         held_ptr <= '0;
      end else if (capture) begin
         held_ptr <= result_a;
      end
   end

   always_comb begin
      if (use_held) begin
         data1 = held_ptr;
      end else begin
         data1 = result_a;
      end
   end

endmodule

// File: design/branch_resolve.sv
// conditional branch and cmov resolution
`timescale 1ns/1ps

module branch_resolve
   import wb_pkg::*;
(
   input  wb_uop_t     uop,
   input  flags_word_t cur_flags,
   output logic        ld_eip,
   output logic        ld_gpr1
);

   logic cf;
   logic zf;

   // conditions come from the stored flags, not the uop's new flags
   assign cf = cur_flags.bits.cf;
   assign zf = cur_flags.bits.zf;

   always_comb begin
      if (uop.is_jne) begin
         ld_eip = ~zf;
      end else if (uop.is_jnbe) begin
         // above means CF and ZF both clear
         ld_eip = ~cf & ~zf;
      end else begin
         ld_eip = uop.ld_eip;
      end
   end

   always_comb begin
      if (uop.is_cmovc) begin
         ld_gpr1 = uop.ld_gpr1 & cf;
      end else begin
         ld_gpr1 = uop.ld_gpr1;
      end
   end

endmodule

// File: design/arch_status_regs.sv
// flags and eip registers
`timescale 1ns/1ps

module arch_status_regs
   import wb_pkg::*;
(
   input  logic        CLK,
   input  logic        rst,
   input  logic        ld_flags,
   input  flags_word_t new_flags,
   input  logic [31:0] affected,
   input  logic        ld_eip,
   input  logic [31:0] next_eip,
   output flags_word_t flags,
   output logic [31:0] eip
);

   // only the affected bits take the new value
   always_ff @(posedge CLK) begin
      if (rst) begin
         flags.raw <= '0;
      end else if (ld_flags) begin
         flags.raw <= (flags.raw & ~affected) | (new_flags.raw & affected);
      end
   end

   always_ff @(posedge CLK) begin
      if (rst) begin
         eip <= '0;
      end else if (ld_eip) begin
         eip <= next_eip;
      end
   end

   // a bad affected mask upstream would leak into the reserved bits
   a_flags_rsvd_zero : assert property (
      @(posedge CLK) disable iff (rst)
      (flags.raw & ~FLAGS_DEFINED_MASK) == '0
   ) else $error("reserved flag bits set: %h", flags.raw);

endmodule

// File: design/dcache_store_master.sv
// wishbone classic store master
`timescale 1ns/1ps

module dcache_store_master
   import wb_pkg::*;
(
   input  logic        CLK,
   input  logic        rst,
   input  logic        req,
   input  logic [31:0] addr,
   input  logic [31:0] data,
   input  datasize_t   size,
   output wb_m2s_t     wbm,
   input  wb_s2m_t     wbs,
   output logic        stall
);

   logic done;
   logic active;

   // cycle after ack keeps cyc low
   always_ff @(posedge CLK) begin
      if (rst) begin
         done <= 1'b0;
      end else begin
         done <= wbm.stb & wbs.ack;
      end
   end

   assign active = req & ~done;

   always_comb begin
      wbm.cyc = active;
      wbm.stb = active;
      wbm.we  = active;
      wbm.adr = addr;
      wbm.dat = data;
      case (size)
         ds_byte: wbm.sel = 4'b0001;
         ds_word: wbm.sel = 4'b0011;
         default: wbm.sel = 4'b1111;
      endcase
   end

   // hold the stage until the slave takes the store
   assign stall = req & ~wbs.ack;

   a_adr_stable : assert property (
      @(posedge CLK) disable iff (rst)
      wbm.stb && !wbs.ack |=> $stable(wbm.adr)
   ) else $error("adr changed during pending store");

   a_ack_needs_stb : assert property (
      @(posedge CLK) disable iff (rst)
      wbs.ack |-> wbm.stb
   ) else $error("ack without stb");

endmodule

// File: design/writeback.sv
// writeback stage
`timescale 1ns/1ps

module writeback
   import wb_pkg::*;
#(
   parameter int NUM_GPR = 8
) (
   input  logic        CLK,
   input  logic        rst,
   input  wb_uop_t     uop,
   input  flags_word_t cur_flags,
   output gpr_wr_t     gpr_wr1,
   output gpr_wr_t     gpr_wr2,
   output gpr_wr_t     gpr_wr3,
   output logic        ld_flags,
   output logic        ld_eip,
   output wb_m2s_t     wbm,
   input  wb_s2m_t     wbs,
   output logic        stall,
   output logic        halt,
   output logic        repne_terminate
);

   logic [31:0] data1;
   logic        res_ld_eip;
   logic        res_ld_gpr1;
   logic        retire;
   logic        store_req;
   logic        count_zero;

   // uop retires this edge
   assign retire    = uop.valid & ~stall;
   assign store_req = uop.valid & uop.store;

   cmps_pointer_hold u_ptr_hold (
      .CLK      (CLK),
      .rst      (rst),
      .capture  (retire & uop.is_cmps_first),
      .use_held (uop.is_cmps_second),
      .result_a (uop.result_a),
      .data1    (data1)
   );

   branch_resolve u_branch (
      .uop       (uop),
      .cur_flags (cur_flags),
      .ld_eip    (res_ld_eip),
      .ld_gpr1   (res_ld_gpr1)
   );

   dcache_store_master u_store (
      .CLK   (CLK),
      .rst   (rst),
      .req   (store_req),
      .addr  (uop.store_addr),
      .data  (data1),
      .size  (uop.datasize),
      .wbm   (wbm),
      .wbs   (wbs),
      .stall (stall)
   );

   always_comb begin
      gpr_wr1.en   = retire & res_ld_gpr1;
      gpr_wr1.num  = uop.dr1;
      gpr_wr1.data = data1;
      gpr_wr1.size = uop.datasize;

      gpr_wr2.en   = retire & uop.ld_gpr2;
      gpr_wr2.num  = uop.dr2;
      gpr_wr2.data = uop.result_b;
      gpr_wr2.size = uop.datasize;

      gpr_wr3.en   = retire & uop.ld_gpr3;
      gpr_wr3.num  = uop.dr3;
      gpr_wr3.data = uop.result_c;
      gpr_wr3.size = uop.datasize;
   end

   assign ld_flags = retire & uop.ld_flags;
   assign ld_eip   = retire & res_ld_eip;

   assign halt = uop.valid & uop.is_halt;

   // result C carries the remaining ecx count
   assign count_zero      = (uop.result_c == '0);
   assign repne_terminate = uop.valid & uop.is_cmps_second & uop.repne &
                            (cur_flags.bits.zf | count_zero);

   a_halt_no_store : assert property (
      @(posedge CLK) disable iff (rst)
      halt |-> !wbm.cyc
   ) else $error("halt uop with a bus store");

endmodule

// File: design/gpr_file.sv
// general purpose register file
`timescale 1ns/1ps

module gpr_file
   import wb_pkg::*;
#(
   parameter int NUM_GPR = 8
) (
   input  logic                       CLK,
   input  logic                       rst,
   input  gpr_wr_t                    wr1,
   input  gpr_wr_t                    wr2,
   input  gpr_wr_t                    wr3,
   input  logic [$clog2(NUM_GPR)-1:0] rd_num,
   output logic [31:0]                rd_data
);

   logic [31:0] regs [NUM_GPR];

   // partial writes keep the upper bits of the old value
   function automatic logic [31:0] merge(
      input logic [31:0] old_val,
      input logic [31:0] new_val,
      input datasize_t   size
   );
      case (size)
         ds_byte: merge = {old_val[31:8], new_val[7:0]};
         ds_word: merge = {old_val[31:16], new_val[15:0]};
         default: merge = new_val;
      endcase
   endfunction

   // later port assignments override earlier ones on a collision
   always_ff @(posedge CLK) begin
      if (rst) begin
         for (int i = 0; i < NUM_GPR; i++) begin
            regs[i] <= '0;
         end
      end else begin
         if (wr1.en) begin
            regs[wr1.num] <= merge(regs[wr1.num], wr1.data, wr1.size);
         end
         if (wr2.en) begin
            regs[wr2.num] <= merge(regs[wr2.num], wr2.data, wr2.size);
         end
         if (wr3.en) begin
            regs[wr3.num] <= merge(regs[wr3.num], wr3.data, wr3.size);
         end
      end
   end

   assign rd_data = regs[rd_num];

   a_port_collision : assert property (
      @(posedge CLK) disable iff (rst)
      !((wr1.en && wr2.en && wr1.num == wr2.num) ||
        (wr1.en && wr3.en && wr1.num == wr3.num) ||
        (wr2.en && wr3.en && wr2.num == wr3.num))
   ) else $warning("two write ports target the same register");

endmodule

// File: design/wb_top.sv
// writeback stage top
`timescale 1ns/1ps

module wb_top
   import wb_pkg::*;
#(
   parameter int NUM_GPR = 8
) (
   input  logic        CLK,
   input  logic        rst,
   input  wb_uop_t     uop,
   input  logic [2:0]  rd_num,
   output logic [31:0] rd_data,
   output flags_word_t flags,
   output logic [31:0] eip,
   output wb_m2s_t     wbm,
   input  wb_s2m_t     wbs,
   output logic        stall,
   output logic        halt,
   output logic        repne_terminate
);

   gpr_wr_t gpr_wr1;
   gpr_wr_t gpr_wr2;
   gpr_wr_t gpr_wr3;
   logic    ld_flags;
   logic    ld_eip;

   writeback #(
      .NUM_GPR (NUM_GPR)
   ) u_writeback (
      .CLK             (CLK),
      .rst             (rst),
      .uop             (uop),
      .cur_flags       (flags),
      .gpr_wr1         (gpr_wr1),
      .gpr_wr2         (gpr_wr2),
      .gpr_wr3         (gpr_wr3),
      .ld_flags        (ld_flags),
      .ld_eip          (ld_eip),
      .wbm             (wbm),
      .wbs             (wbs),
      .stall           (stall),
      .halt            (halt),
      .repne_terminate (repne_terminate)
   );

   gpr_file #(
      .NUM_GPR (NUM_GPR)
   ) u_gpr_file (
      .CLK     (CLK),
      .rst     (rst),
      .wr1     (gpr_wr1),
      .wr2     (gpr_wr2),
      .wr3     (gpr_wr3),
      .rd_num  (rd_num),
      .rd_data (rd_data)
   );

   // flags and eip loads come qualified from the stage
   arch_status_regs u_status (
      .CLK       (CLK),
      .rst       (rst),
      .ld_flags  (ld_flags),
      .new_flags (uop.flags),
      .affected  (uop.flags_affected),
      .ld_eip    (ld_eip),
      .next_eip  (uop.next_eip),
      .flags     (flags),
      .eip       (eip)
   );

endmodule

// File: bench/wb_slave_model.sv
// wishbone slave model
`timescale 1ns/1ps

module wb_slave_model
   import wb_pkg::*;
#(
   parameter int SEED      = 1,
   parameter int MAX_DELAY = 3
) (
   input  logic        CLK,
   input  logic        rst,
   input  wb_m2s_t     wbm,
   output wb_s2m_t     wbs,
   output int          store_count,
   output logic [31:0] last_adr,
   output logic [31:0] last_dat,
   output logic [3:0]  last_sel
);

   int wait_cnt;
   int delay;

   // ack once the drawn number of wait cycles has passed
   assign wbs.ack = wbm.cyc & wbm.stb & (wait_cnt == delay);

   initial begin
      void'($urandom(SEED));
      wait_cnt    = 0;
      store_count = 0;
      last_adr    = '0;
      last_dat    = '0;
      last_sel    = '0;
      delay       = $urandom % (MAX_DELAY + 1);
      forever begin
         @(posedge CLK);
         if (rst) begin
            wait_cnt    <= 0;
            store_count <= 0;
         end else if (wbs.ack) begin
            // log the store and draw the delay for the next one
            wait_cnt    <= 0;
            delay       <= $urandom % (MAX_DELAY + 1);
            store_count <= store_count + 1;
            last_adr    <= wbm.adr;
            last_dat    <= wbm.dat;
            last_sel    <= wbm.sel;
         end else if (wbm.cyc && wbm.stb) begin
            wait_cnt <= wait_cnt + 1;
         end
      end
   end

endmodule

// File: bench/wb_tb.sv
// writeback stage testbench
`timescale 1ns/1ps

module wb_tb
   import wb_pkg::*;
();

   localparam int RESET_CYCLES = 8;
   localparam int STALL_LIMIT  = 20;

   logic        CLK = 1'b0;
   logic        rst;
   wb_uop_t     uop;
   logic [2:0]  rd_num;
   logic [31:0] rd_data;
   flags_word_t flags;
   logic [31:0] eip;
   wb_m2s_t     wbm;
   wb_s2m_t     wbs;
   logic        stall;
   logic        halt;
   logic        repne_terminate;
   int          store_count;
   logic [31:0] log_adr;
   logic [31:0] log_dat;
   logic [3:0]  log_sel;

   // reference model of the architectural state
   logic [31:0] model_regs [8];
   logic [31:0] model_flags;
   logic [31:0] model_eip;
   logic [31:0] model_held;

   // current pattern and its expected values
   string       test_name;
   wb_uop_t     cur;
   int          chk_reg;
   logic [31:0] chk_val;
   logic [31:0] exp_flags;
   logic [31:0] exp_eip;
   logic        exp_halt;
   logic        exp_rterm;
   logic [31:0] exp_sdat;
   logic [3:0]  exp_sel;

   int errors;
   int patterns;
   bit timed_out;

   always begin
      #50 CLK = ~CLK;
   end

   wb_top uut (
      .CLK             (CLK),
      .rst             (rst),
      .uop             (uop),
      .rd_num          (rd_num),
      .rd_data         (rd_data),
      .flags           (flags),
      .eip             (eip),
      .wbm             (wbm),
      .wbs             (wbs),
      .stall           (stall),
      .halt            (halt),
      .repne_terminate (repne_terminate)
   );

   wb_slave_model #(
      .SEED      (49635),
      .MAX_DELAY (3)
   ) u_slave (
      .CLK         (CLK),
      .rst         (rst),
      .wbm         (wbm),
      .wbs         (wbs),
      .store_count (store_count),
      .last_adr    (log_adr),
      .last_dat    (log_dat),
      .last_sel    (log_sel)
   );

   task automatic report_mismatch(input string what, input logic [31:0] expected,
                                  input logic [31:0] actual);
      $display("Fail %s %s: expected %h, actual %h", test_name, what, expected, actual);
      errors++;
   endtask

   // size decides how many low bits of the old value are replaced
   function automatic logic [31:0] merge_write(input logic [31:0] old_val,
                                               input logic [31:0] new_val,
                                               input datasize_t   size);
      logic [31:0] mask;
      mask = 32'hffff_ffff;
      if (size == ds_byte) begin
         mask = 32'h0000_00ff;
      end else if (size == ds_word) begin
         mask = 32'h0000_ffff;
      end
      return (old_val & ~mask) | (new_val & mask);
   endfunction

   task automatic update_model();
      logic [31:0] old_regs [8];
      logic [31:0] data1;
      logic        take_eip;
      logic        take_gpr1;
      old_regs = model_regs;
      if (!cur.valid) begin
         return;
      end
      // conditions use the flags stored before this uop
      take_eip = cur.ld_eip;
      if (cur.is_jne) begin
         take_eip = !model_flags[6];
      end else if (cur.is_jnbe) begin
         take_eip = !model_flags[0] && !model_flags[6];
      end
      take_gpr1 = cur.ld_gpr1 && (!cur.is_cmovc || model_flags[0]);
      data1 = cur.is_cmps_second ? model_held : cur.result_a;
      // ports in order, so port 3 wins a collision
      if (take_gpr1)
         model_regs[cur.dr1] = merge_write(old_regs[cur.dr1], data1, cur.datasize);
      if (cur.ld_gpr2)
         model_regs[cur.dr2] = merge_write(old_regs[cur.dr2], cur.result_b, cur.datasize);
      if (cur.ld_gpr3)
         model_regs[cur.dr3] = merge_write(old_regs[cur.dr3], cur.result_c, cur.datasize);
      if (cur.ld_flags)
         model_flags = (model_flags & ~cur.flags_affected) |
                       (cur.flags.raw & cur.flags_affected);
      if (take_eip)
         model_eip = cur.next_eip;
      if (cur.is_cmps_first)
         model_held = cur.result_a;
   endtask

   task automatic sweep_registers();
      for (int i = 0; i < 8; i++) begin
         @(posedge CLK);
         rd_num <= 3'(i);
         @(negedge CLK);
         if (rd_data !== model_regs[i])
            report_mismatch($sformatf("r%0d", i), model_regs[i], rd_data);
         if (i == chk_reg && rd_data !== chk_val)
            report_mismatch($sformatf("r%0d pattern", i), chk_val, rd_data);
      end
   endtask

   task automatic run_pattern();
      int cycles;
      int stores_before;
      stores_before = store_count;
      @(posedge CLK);
      uop    <= cur;
      rd_num <= cur.dr1;
      @(negedge CLK);
      if (halt !== exp_halt)
         report_mismatch("halt", exp_halt, halt);
      if (repne_terminate !== exp_rterm)
         report_mismatch("repne_terminate", exp_rterm, repne_terminate);
      if (exp_sel != 0) begin
         if ({wbm.cyc, wbm.stb, wbm.we} !== 3'b111)
            report_mismatch("cyc stb we", 3'b111, {wbm.cyc, wbm.stb, wbm.we});
         if (wbm.adr !== cur.store_addr)
            report_mismatch("adr", cur.store_addr, wbm.adr);
         if (wbm.dat !== exp_sdat)
            report_mismatch("dat", exp_sdat, wbm.dat);
         if (wbm.sel !== exp_sel)
            report_mismatch("sel", exp_sel, wbm.sel);
      end else begin
         if (wbm.cyc !== 1'b0)
            report_mismatch("cyc", 1'b0, wbm.cyc);
         if (stall !== 1'b0)
            report_mismatch("stall", 1'b0, stall);
      end
      // nothing may change while the store waits for ack
      cycles = 0;
      while (stall === 1'b1 && !timed_out) begin
         if (rd_data !== model_regs[cur.dr1])
            report_mismatch("register during stall", model_regs[cur.dr1], rd_data);
         if (flags.raw !== model_flags)
            report_mismatch("flags during stall", model_flags, flags.raw);
         if (eip !== model_eip)
            report_mismatch("eip during stall", model_eip, eip);
         @(negedge CLK);
         cycles++;
         if (cycles > STALL_LIMIT) begin
            $display("Error: %s stall still high after %0d cycles", test_name, STALL_LIMIT);
            errors++;
            timed_out = 1'b1;
         end
      end
      if (timed_out) begin
         return;
      end
      @(posedge CLK);
      uop <= '0;
      update_model();
      @(negedge CLK);
      if (flags.raw !== model_flags)
         report_mismatch("flags", model_flags, flags.raw);
      if (flags.raw !== exp_flags)
         report_mismatch("flags pattern", exp_flags, flags.raw);
      if (eip !== model_eip)
         report_mismatch("eip", model_eip, eip);
      if (eip !== exp_eip)
         report_mismatch("eip pattern", exp_eip, eip);
      if (wbm.cyc !== 1'b0)
         report_mismatch("cyc after retire", 1'b0, wbm.cyc);
      if (exp_sel != 0) begin
         if (store_count != stores_before + 1)
            report_mismatch("stores logged", stores_before + 1, store_count);
         if (log_adr !== cur.store_addr)
            report_mismatch("logged adr", cur.store_addr, log_adr);
         if (log_dat !== exp_sdat)
            report_mismatch("logged dat", exp_sdat, log_dat);
         if (log_sel !== exp_sel)
            report_mismatch("logged sel", exp_sel, log_sel);
      end else if (store_count != stores_before) begin
         $display("Error: %s started a bus store that it should not", test_name);
         errors++;
      end
      sweep_registers();
   endtask

   initial begin
      int          fd;
      int          n;
      string       line;
      logic        valid_i;
      logic [31:0] eip_i;
      logic [31:0] ra;
      logic [31:0] rb;
      logic [31:0] rc;
      logic [31:0] fl;
      logic [31:0] aff;
      logic [31:0] sadr;
      logic [5:0]  ld;
      logic [6:0]  op;
      int          ds;
      int          d1;
      int          d2;
      int          d3;
      errors     = 0;
      patterns   = 0;
      timed_out  = 1'b0;
      rst        = 1'b1;
      uop        = '0;
      rd_num     = '0;
      model_flags = '0;
      model_eip  = '0;
      model_held = '0;
      for (int i = 0; i < 8; i++) begin
         model_regs[i] = '0;
      end
      repeat (RESET_CYCLES) @(posedge CLK);
      rst <= 1'b0;
      test_name = "reset";
      chk_reg   = -1;
      @(negedge CLK);
      if ({wbm.cyc, wbm.stb, stall, halt, repne_terminate} !== 5'b0)
         report_mismatch("control outputs", 5'b0,
                         {wbm.cyc, wbm.stb, stall, halt, repne_terminate});
      if (flags.raw !== 32'h0)
         report_mismatch("flags", 32'h0, flags.raw);
      if (eip !== 32'h0)
         report_mismatch("eip", 32'h0, eip);
      sweep_registers();

      fd = $fopen("bench/wb_patterns.txt", "r");
      if (fd == 0) begin
         $display("Error: cannot open bench/wb_patterns.txt");
         errors++;
      end else begin
         while (!$feof(fd) && !timed_out) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.getc(0) == "#") begin
               continue;
            end
            n = $sscanf(line,
               "%s %h %h %d %d %d %d %h %h %h %h %h %h %b %b %d %h %h %h %h %h %h %h",
               test_name, valid_i, eip_i, ds, d1, d2, d3, ra, rb, rc, fl, aff, sadr,
               ld, op, chk_reg, chk_val, exp_flags, exp_eip, exp_halt, exp_rterm,
               exp_sdat, exp_sel);
            if (n != 23) begin
               $display("Error: malformed pattern line: %s", line);
               errors++;
               continue;
            end
            cur                = '0;
            cur.valid          = valid_i;
            cur.next_eip       = eip_i;
            cur.datasize       = datasize_t'(ds);
            cur.dr1            = 3'(d1);
            cur.dr2            = 3'(d2);
            cur.dr3            = 3'(d3);
            cur.result_a       = ra;
            cur.result_b       = rb;
            cur.result_c       = rc;
            cur.flags.raw      = fl;
            cur.flags_affected = aff;
            cur.store_addr     = sadr;
            {cur.ld_gpr1, cur.ld_gpr2, cur.ld_gpr3, cur.ld_flags, cur.ld_eip,
             cur.store} = ld;
            {cur.is_cmps_first, cur.is_cmps_second, cur.is_jne, cur.is_jnbe,
             cur.is_cmovc, cur.is_halt, cur.repne} = op;
            patterns++;
            run_pattern();
         end
         $fclose(fd);
      end

      $display("patterns %0d, errors %0d", patterns, errors);
      if (errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

// File: bench/wb_patterns.txt
# name valid eip size dr1 dr2 dr3 res_a res_b res_c flags affected st_addr ld op, with
# ld = gpr1 gpr2 gpr3 flags eip store, op = cmps1 cmps2 jne jnbe cmovc halt repne
# expected: reg value flags eip halt repne_term st_data st_sel (sel 0 means no store)
dword_write 1 1003 2 1 2 3 11223344 a5a5a5a5 0f0f0f0f 0 0 0 111010 0000000 2 a5a5a5a5 0 1003 0 0 0 0
byte_merge 1 1005 0 1 0 0 000000ee 0 0 0 0 0 100010 0000000 1 112233ee 0 1005 0 0 0 0
word_merge 1 1008 1 0 2 0 0 0000beef 0 0 0 0 010010 0000000 2 a5a5beef 0 1008 0 0 0 0
byte_three 1 100a 0 4 5 3 000000aa ffffffbb 000000cc 0 0 0 111010 0000000 3 0f0f0fcc 0 100a 0 0 0 0
collide_1_3 1 100c 2 6 0 6 11111111 0 33333333 0 0 0 101010 0000000 6 33333333 0 100c 0 0 0 0
collide_1_2 1 1010 1 7 7 0 0000aaaa 0000bbbb 0 0 0 0 110010 0000000 7 0000bbbb 0 1010 0 0 0 0
flags_zf_cf 1 1012 2 0 0 0 0 0 0 cd5 041 0 000110 0000000 1 112233ee 041 1012 0 0 0 0
flags_sf 1 1014 2 0 0 0 0 0 0 080 0c0 0 000110 0000000 1 112233ee 081 1014 0 0 0 0
jne_taken 1 2000 2 0 0 0 0 0 0 0 0 0 000000 0010000 0 00000000 081 2000 0 0 0 0
jnbe_cf_set 1 3000 2 0 0 0 0 0 0 0 0 0 000000 0001000 0 00000000 081 2000 0 0 0 0
cmovc_taken 1 2001 2 0 0 0 cafef00d 0 0 0 0 0 100000 0000100 0 cafef00d 081 2000 0 0 0 0
flags_zf 1 2002 2 0 0 0 0 0 0 040 041 0 000110 0000000 0 cafef00d 0c0 2002 0 0 0 0
jne_zf_set 1 4000 2 0 0 0 0 0 0 0 0 0 000000 0010000 0 cafef00d 0c0 2002 0 0 0 0
jnbe_zf_set 1 4100 2 0 0 0 0 0 0 0 0 0 000000 0001000 0 cafef00d 0c0 2002 0 0 0 0
cmovc_cf_clr 1 2003 2 1 0 0 deadbeef 0 0 0 0 0 100000 0000100 1 112233ee 0c0 2002 0 0 0 0
flags_clear 1 2004 2 0 0 0 0 0 0 0 cd5 0 000110 0000000 0 cafef00d 0 2004 0 0 0 0
jnbe_taken 1 5000 2 0 0 0 0 0 0 0 0 0 000000 0001000 0 cafef00d 0 5000 0 0 0 0
store_dword 1 5004 2 4 0 0 12345678 0 0 0 0 100 100011 0000000 4 12345678 0 5004 0 0 12345678 f
store_byte 1 5006 0 5 0 0 000000a7 0 0 0 0 101 100011 0000000 5 000000a7 0 5006 0 0 000000a7 1
store_word 1 5008 1 6 0 0 0000c3d2 0 0 0 0 202 100011 0000000 6 3333c3d2 0 5008 0 0 0000c3d2 3
store_only 1 500c 2 0 0 0 0badf00d 0 0 0 0 300 000011 0000000 0 cafef00d 0 500c 0 0 0badf00d f
cmps_first_a 1 6000 2 0 0 0 00002000 0 0 0 0 0 000010 1000000 0 cafef00d 0 6000 0 0 0 0
cmps_second_a 1 6002 2 7 0 1 ffffffff 0 00000005 0 0 0 101010 0100001 7 00002000 0 6002 0 0 0 0
cmps_first_b 1 6004 2 0 0 0 00003000 0 0 040 040 0 000110 1000000 7 00002000 040 6004 0 0 0 0
cmps_zf_stop 1 6006 2 7 0 1 ffffffff 0 00000004 0 0 0 101010 0100001 7 00003000 040 6006 0 1 0 0
flags_zf_clr 1 6008 2 0 0 0 0 0 0 0 040 0 000110 0000000 1 00000004 0 6008 0 0 0 0
cmps_first_c 1 600a 2 0 0 0 00004000 0 0 0 0 0 000010 1000000 0 cafef00d 0 600a 0 0 0 0
cmps_count_0 1 600c 2 2 0 3 ffffffff 0 00000000 0 0 0 101010 0100001 2 00004000 0 600c 0 1 0 0
cmps_no_rep 1 600e 0 5 0 0 ffffffff 0 0 0 0 0 100010 0100000 5 00000000 0 600e 0 0 0 0
halt 1 7000 2 0 0 0 0 0 0 0 0 0 000010 0000010 0 cafef00d 0 7000 1 0 0 0
inval_all 0 9999 2 0 1 2 ffffffff ffffffff 0 ff cd5 400 111111 0100011 0 cafef00d 0 7000 0 0 0 0
inval_jne 0 8888 2 0 0 0 0 0 0 0 0 0 000010 0010000 0 cafef00d 0 7000 0 0 0 0
dword_r0 1 7004 2 0 0 0 01020304 0 0 0 0 0 100010 0000000 0 01020304 0 7004 0 0 0 0
store_flags 1 7008 2 0 0 0 55aa55aa 0 0 801 801 ffc 000111 0000000 0 01020304 801 7008 0 0 55aa55aa f

// File: src.f
design/wb_pkg.sv
design/cmps_pointer_hold.sv
design/branch_resolve.sv
design/arch_status_regs.sv
design/dcache_store_master.sv
design/writeback.sv
design/gpr_file.sv
design/wb_top.sv
bench/wb_slave_model.sv
bench/wb_tb.sv
